/* Bender.yml */
package:
  name: hwpe_ctrl_regfile

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - hwpe_ctrl_pkg.sv
      - hwpe_job_tracker.sv
      - hwpe_param_store.sv
      - hwpe_read_merge.sv
      - hwpe_ctrl_regfile.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_hwpe_ctrl_regfile.sv

/* hwpe_ctrl_pkg.sv */
/*
 * Types of the HWPE control register file: register word, job id,
 * context and address vectors, bus request and access-flag structs,
 * and the parameter bus seen by the engine
 */

`include "hwpe_ctrl_settings.svh"

package hwpe_ctrl_pkg;

  typedef logic [31:0] reg_word_t;
  typedef logic [7:0]  job_id_t;
  typedef logic [`HWPE_LOG_CONTEXT-1:0] context_t;
  typedef logic [`HWPE_LOG_REGS+`HWPE_LOG_CONTEXT-1:0] reg_addr_t; // {context, register}
  typedef logic [3:0]  byte_en_t;

  // One bus access as seen by the register file
  typedef struct packed {
    reg_addr_t addr;
    logic      wren;
    byte_en_t  be;
    reg_word_t wdata;
  } regfile_req_t;

  // Access flags decoded by the engine controller
  typedef struct packed {
    logic     is_read;
    logic     is_testset;
    logic     is_mandatory;
    logic     is_contexted;
    logic     is_trigger;
    logic     is_critical;
    logic     full_context;
    logic     true_done;
    context_t pointer_context;  // Context software is filling
    context_t running_context;  // Context the engine executes
  } regfile_flags_t;

  // Parameter words of the running context
  typedef reg_word_t [`HWPE_N_IO_REGS-1:0] hwpe_params_t;

endpackage

/* hwpe_ctrl_regfile.sv */
/*
 * HWPE control register file top: job tracker,
 * parameter store and read merge wired together
 */

`timescale 1ns/1ps

module hwpe_ctrl_regfile (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          clear_i,
  input  hwpe_ctrl_pkg::regfile_req_t   req_i,
  input  hwpe_ctrl_pkg::regfile_flags_t flags_i,
  output hwpe_ctrl_pkg::reg_word_t      rdata_o,
  output hwpe_ctrl_pkg::hwpe_params_t   hwpe_params_o
);

  import hwpe_ctrl_pkg::*;

  reg_word_t  testset_rdata;
  job_id_t    running_id;
  reg_word_t  status_word;
  logic [1:0] finished_cnt;
  reg_word_t  param_rdata;

  hwpe_job_tracker i_job_tracker (
    .clk_i           ( clk_i         ),
    .rst_ni          ( rst_ni        ),
    .clear_i         ( clear_i       ),
    .req_i           ( req_i         ),
    .flags_i         ( flags_i       ),
    .testset_rdata_o ( testset_rdata ),
    .running_id_o    ( running_id    ),
    .status_word_o   ( status_word   ),
    .finished_cnt_o  ( finished_cnt  )
  );

  hwpe_param_store i_param_store (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .clear_i       ( clear_i       ),
    .req_i         ( req_i         ),
    .flags_i       ( flags_i       ),
    .param_rdata_o ( param_rdata   ),
    .hwpe_params_o ( hwpe_params_o )
  );

  hwpe_read_merge i_read_merge (
    .clk_i           ( clk_i         ),
    .rst_ni          ( rst_ni        ),
    .clear_i         ( clear_i       ),
    .req_i           ( req_i         ),
    .flags_i         ( flags_i       ),
    .testset_rdata_i ( testset_rdata ),
    .running_id_i    ( running_id    ),
    .status_word_i   ( status_word   ),
    .finished_cnt_i  ( finished_cnt  ),
    .param_rdata_i   ( param_rdata   ),
    .rdata_o         ( rdata_o       )
  );

endmodule

/* hwpe_ctrl_settings.svh */
/*
 * Sizing and encoding macros for the HWPE control register file:
 * context and register counts, address field widths,
 * mandatory register offsets and test-and-set reply codes
 */

`ifndef HWPE_CTRL_SETTINGS_SVH
`define HWPE_CTRL_SETTINGS_SVH

// Geometry
`define HWPE_N_CONTEXT    2
`define HWPE_N_IO_REGS    4
`define HWPE_LOG_REGS     4   // 16 registers per context
`define HWPE_LOG_CONTEXT  1   // Context field above the register field
`define HWPE_N_MANDATORY  8

// Mandatory word offsets
`define HWPE_ADDR_FINISHED   2
`define HWPE_ADDR_STATUS     3
`define HWPE_ADDR_RUNNING    4
`define HWPE_ADDR_SOFTCLEAR  5

// Test-and-set replies, -2 and -1 as 32-bit words
`define HWPE_RESP_OTHER_PE  32'hFFFF_FFFE
`define HWPE_RESP_ALL_BUSY  32'hFFFF_FFFF

// Returned for mandatory offsets with no register behind them
`define HWPE_UNKNOWN_WORD   32'hDEAD_BEEF

`endif

/* hwpe_job_tracker.sv */
/*
 * Job bookkeeping: offload and running job id counters,
 * registered test-and-set reply, per-context status bytes
 * and the saturating finished-job counter
 */

`timescale 1ns/1ps
`include "hwpe_ctrl_settings.svh"

module hwpe_job_tracker (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          clear_i,
  input  hwpe_ctrl_pkg::regfile_req_t   req_i,
  input  hwpe_ctrl_pkg::regfile_flags_t flags_i,
  output hwpe_ctrl_pkg::reg_word_t      testset_rdata_o,
  output hwpe_ctrl_pkg::job_id_t        running_id_o,
  output hwpe_ctrl_pkg::reg_word_t      status_word_o,
  output logic [1:0]                    finished_cnt_o
);

  import hwpe_ctrl_pkg::*;

  job_id_t   offload_id_q;
  logic      offload_incr_q;
  job_id_t   running_id_q;
  logic      running_incr_q;
  reg_word_t testset_rdata_q;
  logic [7:0] status_q [`HWPE_N_CONTEXT];
  logic [1:0] finished_q;
  logic       finished_access;

  // Test-and-set reply, the id advances on the cycle after a granted slot
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      testset_rdata_q <= '0;
      offload_incr_q  <= 1'b0;
    end else if (clear_i) begin
      testset_rdata_q <= '0;
      offload_incr_q  <= 1'b0;
    end else begin
      offload_incr_q <= 1'b0;
      if (flags_i.is_testset) begin
        if (flags_i.is_critical) begin
          testset_rdata_q <= `HWPE_RESP_OTHER_PE;
        end else if (flags_i.full_context) begin
          testset_rdata_q <= `HWPE_RESP_ALL_BUSY;
        end else begin
          testset_rdata_q <= reg_word_t'(offload_id_q);
          offload_incr_q  <= 1'b1;
        end
      end
    end
  end

  // Job id counters, completion is seen one cycle late
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      offload_id_q   <= '0;
      running_id_q   <= '0;
      running_incr_q <= 1'b0;
    end else if (clear_i) begin
      offload_id_q   <= '0;
      running_id_q   <= '0;
      running_incr_q <= 1'b0;
    end else begin
      running_incr_q <= flags_i.true_done;
      if (offload_incr_q) offload_id_q <= offload_id_q + 8'd1;
      if (running_incr_q) running_id_q <= running_id_q + 8'd1;
    end
  end

  // Status bytes, a trigger on the pointed context wins over a done
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int c = 0; c < `HWPE_N_CONTEXT; c++) status_q[c] <= 8'h00;
    end else if (clear_i) begin
      for (int c = 0; c < `HWPE_N_CONTEXT; c++) status_q[c] <= 8'h00;
    end else begin
      for (int c = 0; c < `HWPE_N_CONTEXT; c++) begin
        if (flags_i.is_trigger && flags_i.pointer_context == context_t'(c)) begin
          status_q[c] <= 8'h01;
        end else if (flags_i.true_done && flags_i.running_context == context_t'(c)) begin
          status_q[c] <= 8'h00;
        end
      end
    end
  end

  always_comb begin
    status_word_o = '0; // Unused context bytes stay zero
    for (int c = 0; c < `HWPE_N_CONTEXT; c++) status_word_o[8*c +: 8] = status_q[c];
  end

  // Finished counter, read-to-clear from software
  assign finished_access = flags_i.is_mandatory &&
                           (req_i.addr[`HWPE_LOG_REGS-1:0] == `HWPE_ADDR_FINISHED);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      finished_q <= 2'd0;
    end else if (clear_i || finished_access) begin
      finished_q <= 2'd0;
    end else if (flags_i.true_done && finished_q < 2'd2) begin
      finished_q <= finished_q + 2'd1;
    end
  end

  assign testset_rdata_o = testset_rdata_q;
  assign running_id_o    = running_id_q;
  assign finished_cnt_o  = finished_q;

  for (genvar c = 0; c < `HWPE_N_CONTEXT; c++) begin : gen_status_chk
    assert property (@(posedge clk_i) disable iff (!rst_ni) status_q[c] <= 8'h01)
      else $error("Status byte %0d holds %0h", c, status_q[c]);
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni) finished_q <= 2'd2)
    else $error("Finished count %0d above saturation", finished_q);

endmodule

/* hwpe_param_store.sv */
/*
 * Per-context I/O parameter registers with byte-enabled writes,
 * address to context/slot mapping, registered read port
 * and the running context's words for the engine
 */

`timescale 1ns/1ps
`include "hwpe_ctrl_settings.svh"

module hwpe_param_store (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          clear_i,
  input  hwpe_ctrl_pkg::regfile_req_t   req_i,
  input  hwpe_ctrl_pkg::regfile_flags_t flags_i,
  output hwpe_ctrl_pkg::reg_word_t      param_rdata_o,
  output hwpe_ctrl_pkg::hwpe_params_t   hwpe_params_o
);

  import hwpe_ctrl_pkg::*;

  hwpe_params_t params_q [`HWPE_N_CONTEXT];
  reg_word_t    rdata_q;
  context_t     ctx;
  logic [`HWPE_LOG_REGS-1:0] slot;
  logic         slot_ok;
  logic         wr_en;

  // Parameter slots sit right above the mandatory block
  assign slot    = req_i.addr[`HWPE_LOG_REGS-1:0] - `HWPE_LOG_REGS'(`HWPE_N_MANDATORY);
  assign slot_ok = slot < `HWPE_LOG_REGS'(`HWPE_N_IO_REGS);
  assign ctx     = flags_i.is_contexted ? req_i.addr[`HWPE_LOG_REGS +: `HWPE_LOG_CONTEXT] : '0;
  assign wr_en   = req_i.wren && !flags_i.is_mandatory && slot_ok;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int c = 0; c < `HWPE_N_CONTEXT; c++) params_q[c] <= '0;
    end else if (clear_i) begin
      for (int c = 0; c < `HWPE_N_CONTEXT; c++) params_q[c] <= '0;
    end else if (wr_en) begin
      for (int b = 0; b < 4; b++) begin
        if (req_i.be[b]) params_q[ctx][slot][8*b +: 8] <= req_i.wdata[8*b +: 8];
      end
    end
  end

  // Read word is held until the next parameter read
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (clear_i) begin
      rdata_q <= '0;
    end else if (flags_i.is_read && !flags_i.is_mandatory) begin
      rdata_q <= slot_ok ? params_q[ctx][slot] : '0;
    end
  end

  assign param_rdata_o = rdata_q;
  assign hwpe_params_o = params_q[flags_i.running_context]; // Follows context switches at once

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (req_i.wren && !flags_i.is_mandatory) |-> slot_ok)
    else $error("Parameter write to slot %0d out of range", slot);

endmodule

/* hwpe_read_merge.sv */
/*
 * Mandatory register read path and final read-data mux
 * between test-and-set reply, mandatory word and parameter word
 */

`timescale 1ns/1ps
`include "hwpe_ctrl_settings.svh"

module hwpe_read_merge (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          clear_i,
  input  hwpe_ctrl_pkg::regfile_req_t   req_i,
  input  hwpe_ctrl_pkg::regfile_flags_t flags_i,
  input  hwpe_ctrl_pkg::reg_word_t      testset_rdata_i,
  input  hwpe_ctrl_pkg::job_id_t        running_id_i,
  input  hwpe_ctrl_pkg::reg_word_t      status_word_i,
  input  logic [1:0]                    finished_cnt_i,
  input  hwpe_ctrl_pkg::reg_word_t      param_rdata_i,
  output hwpe_ctrl_pkg::reg_word_t      rdata_o
);

  import hwpe_ctrl_pkg::*;

  logic      access;
  logic      was_testset_q;
  logic      was_mandatory_q;
  reg_word_t mand_word_d;
  reg_word_t mand_word_q;

  assign access = flags_i.is_read || flags_i.is_testset;

  always_comb begin
    case (req_i.addr[`HWPE_LOG_REGS-1:0])
      `HWPE_ADDR_FINISHED:  mand_word_d = reg_word_t'(finished_cnt_i);
      `HWPE_ADDR_STATUS:    mand_word_d = status_word_i;
      `HWPE_ADDR_RUNNING:   mand_word_d = reg_word_t'(running_id_i);
      `HWPE_ADDR_SOFTCLEAR: mand_word_d = '0;
      default:              mand_word_d = `HWPE_UNKNOWN_WORD;
    endcase
  end

  // Source selection is captured along with the word
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mand_word_q     <= '0;
      was_testset_q   <= 1'b0;
      was_mandatory_q <= 1'b0;
    end else if (clear_i) begin
      mand_word_q     <= '0;
      was_testset_q   <= 1'b0;
      was_mandatory_q <= 1'b0;
    end else if (access) begin
      mand_word_q     <= mand_word_d;
      was_testset_q   <= flags_i.is_testset;
      was_mandatory_q <= flags_i.is_mandatory;
    end
  end

  // Test-and-set takes precedence over everything else
  assign rdata_o = was_testset_q   ? testset_rdata_i :
                   was_mandatory_q ? mand_word_q     : param_rdata_i;

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(flags_i.is_testset && flags_i.is_trigger))
    else $error("Test-and-set and trigger in the same cycle");

endmodule

/* project.f */
+incdir+.
hwpe_ctrl_pkg.sv
hwpe_job_tracker.sv
hwpe_param_store.sv
hwpe_read_merge.sv
hwpe_ctrl_regfile.sv
tb_hwpe_ctrl_regfile.sv

/* tb_hwpe_ctrl_regfile.sv */
/*
 * Testbench for the HWPE control register file: parameter writes,
 * test-and-set, status bytes, job counters and mandatory reads,
 * checked by concurrent assertions against a scoreboard model
 */

`timescale 1ns/1ps
`include "hwpe_ctrl_settings.svh"

module tb_hwpe_ctrl_regfile;

  import hwpe_ctrl_pkg::*;

  localparam int TIMEOUT_CYCLES = 2000;

  logic           clk_i = 1'b0;
  logic           rst_ni;
  logic           clear_i;
  regfile_req_t   req;
  regfile_flags_t flags;
  reg_word_t      rdata;
  hwpe_params_t   hwpe_params;

  // Scoreboard model
  hwpe_params_t params_m [`HWPE_N_CONTEXT];
  logic [7:0]   status_m [`HWPE_N_CONTEXT];
  job_id_t      offload_m;
  job_id_t      running_m;
  int           finished_m;
  context_t     ptr_ctx;
  context_t     run_ctx;

  reg_word_t    exp_word;
  reg_word_t    exp_q;
  hwpe_params_t exp_params;
  logic         chk_rd;
  logic         chk_par;
  logic         chk_q = 1'b0;
  reg_word_t    lcg_state = 32'd38;
  int           cycles = 0;
  int           err_cnt = 0;
  int           chk_cnt = 0;
  int           test_err0 = 0;

  hwpe_ctrl_regfile dut0 (
    .clk_i         ( clk_i       ),
    .rst_ni        ( rst_ni      ),
    .clear_i       ( clear_i     ),
    .req_i         ( req         ),
    .flags_i       ( flags       ),
    .rdata_o       ( rdata       ),
    .hwpe_params_o ( hwpe_params )
  );

  always #10 clk_i = ~clk_i;

  // Expected word lines up with rdata_o one cycle after the access
  always @(posedge clk_i) begin
    chk_q <= chk_rd;
    exp_q <= exp_word;
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the stimulus did not finish", cycles);
      $display("Errors found");
      $finish;
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni) chk_q |-> rdata == exp_q)
    else begin
      err_cnt++;
      $display("Fail at %0t: rdata_o expected %h, got %h", $time, $sampled(exp_q),
               $sampled(rdata));
    end

  assert property (@(posedge clk_i) disable iff (!rst_ni) chk_par |-> hwpe_params == exp_params)
    else begin
      err_cnt++;
      $display("Fail at %0t: hwpe_params_o expected %h, got %h", $time, $sampled(exp_params),
               $sampled(hwpe_params));
    end

  function automatic reg_word_t next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic void reset_model();
    for (int c = 0; c < `HWPE_N_CONTEXT; c++) begin
      params_m[c] = '0;
      status_m[c] = 8'h00;
    end
    offload_m  = '0;
    running_m  = '0;
    finished_m = 0;
  endfunction

  // Back to an idle bus on the next falling edge
  task automatic next_cycle();
    @(negedge clk_i);
    req     = '0;
    flags   = '0;
    flags.pointer_context = ptr_ctx;
    flags.running_context = run_ctx;
    clear_i = 1'b0;
    chk_rd  = 1'b0;
    chk_par = 1'b0;
  endtask

  task automatic expect_word(reg_word_t w);
    exp_word = w;
    chk_rd   = 1'b1;
    chk_cnt++;
  endtask

  task automatic write_param(context_t ctx, int slot, byte_en_t be);
    reg_word_t data;
    data = next_rand();
    next_cycle();
    req.addr  = {ctx, `HWPE_LOG_REGS'(`HWPE_N_MANDATORY + slot)};
    req.wren  = 1'b1;
    req.be    = be;
    req.wdata = data;
    flags.is_contexted = 1'b1;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) params_m[ctx][slot][8*b +: 8] = data[8*b +: 8]; // Only enabled bytes change
    end
  endtask

  task automatic read_param(context_t ctx, int slot);
    next_cycle();
    req.addr = {ctx, `HWPE_LOG_REGS'(`HWPE_N_MANDATORY + slot)};
    flags.is_read      = 1'b1;
    flags.is_contexted = 1'b1;
    expect_word(params_m[ctx][slot]);
  endtask

  task automatic read_mand(int offset);
    next_cycle();
    req.addr = reg_addr_t'(offset);
    flags.is_read      = 1'b1;
    flags.is_mandatory = 1'b1;
    if (offset == `HWPE_ADDR_FINISHED) begin
      expect_word(reg_word_t'(finished_m));
      finished_m = 0; // Read clears the counter
    end else if (offset == `HWPE_ADDR_STATUS) begin
      expect_word({16'h0000, status_m[1], status_m[0]});
    end else if (offset == `HWPE_ADDR_RUNNING) begin
      expect_word(reg_word_t'(running_m));
    end else if (offset == `HWPE_ADDR_SOFTCLEAR) begin
      expect_word('0);
    end else begin
      expect_word(`HWPE_UNKNOWN_WORD);
    end
  endtask

  task automatic testset(logic crit, logic full);
    next_cycle();
    flags.is_testset   = 1'b1;
    flags.is_critical  = crit;
    flags.full_context = full;
    if (crit) begin
      expect_word(`HWPE_RESP_OTHER_PE);
    end else if (full) begin
      expect_word(`HWPE_RESP_ALL_BUSY);
    end else begin
      expect_word(reg_word_t'(offload_m));
      offload_m++;
    end
    next_cycle(); // Offload id moves one cycle later
  endtask

  task automatic trigger(context_t ctx);
    next_cycle();
    ptr_ctx = ctx;
    flags.pointer_context = ctx;
    flags.is_trigger      = 1'b1;
    status_m[ctx] = 8'h01;
  endtask

  task automatic job_done();
    next_cycle();
    flags.true_done = 1'b1;
    status_m[run_ctx] = 8'h00;
    if (finished_m < 2) finished_m++;
    running_m++;
    next_cycle(); // Running id increment is registered
  endtask

  task automatic set_running(context_t ctx);
    next_cycle();
    run_ctx = ctx;
    flags.running_context = ctx;
    exp_params = params_m[ctx];
    chk_par    = 1'b1;
    chk_cnt++;
  endtask

  task automatic pulse_clear();
    next_cycle();
    clear_i = 1'b1;
    reset_model();
  endtask

  task automatic end_test(string name);
    next_cycle();
    next_cycle();
    $display("Test %s finished with %0d errors", name, err_cnt - test_err0);
    test_err0 = err_cnt;
  endtask

  initial begin
    rst_ni     = 1'b0;
    clear_i    = 1'b0;
    req        = '0;
    flags      = '0;
    ptr_ctx    = '0;
    run_ctx    = '0;
    chk_rd     = 1'b0;
    chk_par    = 1'b0;
    exp_word   = '0;
    exp_params = '0;
    reset_model();
    repeat (4) @(negedge clk_i);
    rst_ni = 1'b1;

    for (int c = 0; c < `HWPE_N_CONTEXT; c++) begin
      for (int s = 0; s < `HWPE_N_IO_REGS; s++) begin
        write_param(context_t'(c), s, 4'hF);
        write_param(context_t'(c), s, byte_en_t'(next_rand() >> 28)); // Mixed enables
      end
    end
    for (int c = 0; c < `HWPE_N_CONTEXT; c++) begin
      for (int s = 0; s < `HWPE_N_IO_REGS; s++) read_param(context_t'(c), s);
    end
    set_running(1'b1);
    set_running(1'b0);
    end_test("parameters");

    testset(1'b0, 1'b0);
    testset(1'b0, 1'b0);
    testset(1'b0, 1'b0);
    testset(1'b1, 1'b0);
    testset(1'b0, 1'b1);
    testset(1'b0, 1'b0); // Id 3 after the refused requests
    end_test("test-and-set");

    trigger(1'b0);
    trigger(1'b1);
    read_mand(`HWPE_ADDR_STATUS);
    job_done();
    read_mand(`HWPE_ADDR_STATUS);
    end_test("status");

    job_done();
    job_done();
    read_mand(`HWPE_ADDR_RUNNING);
    read_mand(`HWPE_ADDR_FINISHED);
    read_mand(`HWPE_ADDR_FINISHED);
    end_test("job counters");

    read_mand(0);
    read_mand(1);
    read_mand(6);
    read_mand(7);
    read_mand(`HWPE_ADDR_SOFTCLEAR);
    job_done(); // Finished count is nonzero going into the clear
    pulse_clear();
    read_mand(`HWPE_ADDR_RUNNING);
    read_mand(`HWPE_ADDR_STATUS);
    read_mand(`HWPE_ADDR_FINISHED);
    testset(1'b0, 1'b0);
    end_test("unknown offsets and clear");

    $display("Tests: 5, checks: %0d, errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule
